/* logic/mesh_pkg.sv */
package mesh_pkg;

  // Mesh geometry
  // --------------------
  localparam int X_NODES    = 4;                  // Columns
  localparam int Y_NODES    = 4;                  // Rows
  localparam int NUM_NODES  = X_NODES * Y_NODES;  // One node per router
  localparam int NUM_PORTS  = 5;                  // Local plus four neighbours
  localparam int FIFO_DEPTH = 4;                  // Entries per input FIFO

  // Field widths
  // --------------------
  typedef logic [1:0]  coord_t;       // X or Y position in the grid
  typedef logic [3:0]  node_id_t;     // y * X_NODES + x
  typedef logic [15:0] payload_t;     // User data
  typedef logic [2:0]  fifo_count_t;  // 0 .. FIFO_DEPTH inclusive

  // Router port numbering, same order on every router
  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,  // Attached node
    PORT_NORTH = 3'd1,  // Higher y
    PORT_EAST  = 3'd2,  // Higher x
    PORT_SOUTH = 3'd3,  // Lower y
    PORT_WEST  = 3'd4   // Lower x
  } port_e;

  // Output arbiter FSM
  typedef enum logic {
    ARB_IDLE = 1'b0,    // Output register empty
    ARB_HOLD = 1'b1     // Word waiting for downstream enable
  } arb_state_e;

  // Single-flit packet
  // --------------------
  typedef struct packed {
    coord_t   dst_x;    // Destination column
    coord_t   dst_y;    // Destination row
    node_id_t src;      // Injecting node
    payload_t payload;
  } packet_t;

endpackage

/* logic/mesh_input_fifo.sv */
`timescale 1ns/1ps

module mesh_input_fifo (
  input  logic              clk,
  input  logic              i_rst,
  // Upstream link, valid/enable
  input  mesh_pkg::packet_t i_data,
  input  logic              i_data_val,
  output logic              o_en,
  // Head side, toward the output arbiters
  input  logic              i_pop,
  output mesh_pkg::packet_t o_head,
  output logic              o_head_val
);

  mesh_pkg::packet_t mem [mesh_pkg::FIFO_DEPTH];     // Circular buffer
  logic [$clog2(mesh_pkg::FIFO_DEPTH)-1:0] wr_ptr;   // Next free slot
  logic [$clog2(mesh_pkg::FIFO_DEPTH)-1:0] rd_ptr;   // Current head
  mesh_pkg::fifo_count_t count;                      // Occupancy
  mesh_pkg::fifo_count_t count_nxt;
  logic push;
  logic pop;

  assign push = i_data_val && o_en;  // Link transfer this edge
  assign pop  = i_pop && o_head_val; // Head taken by a granted arbiter

  // Occupancy counter
  // --------------------
  always_comb begin
    case ({push, pop})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;    // Idle, or push and pop cancel out
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      count  <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      o_en   <= 1'b1;                // Empty after reset, ready at once
    end else begin
      count <= count_nxt;
      // Enable drops only when the buffer will be full
      o_en  <= (count_nxt != mesh_pkg::fifo_count_t'(mesh_pkg::FIFO_DEPTH));
      if (push) begin
        wr_ptr <= (wr_ptr == mesh_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == mesh_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= i_data;
  end

  assign o_head     = mem[rd_ptr];   // Visible the cycle after the write
  assign o_head_val = (count != '0);

endmodule

/* logic/mesh_output_arbiter.sv */
`timescale 1ns/1ps

module mesh_output_arbiter (
  input  logic                           clk,
  input  logic                           i_rst,
  // Requests from the five input FIFO heads
  input  logic [mesh_pkg::NUM_PORTS-1:0] i_req,
  input  mesh_pkg::packet_t              i_heads [mesh_pkg::NUM_PORTS],
  output logic [mesh_pkg::NUM_PORTS-1:0] o_grant,   // One-hot, also the FIFO pop
  // Downstream link, valid/enable
  output mesh_pkg::packet_t              o_data,
  output logic                           o_data_val,
  input  logic                           i_en
);

  mesh_pkg::arb_state_e state;
  mesh_pkg::arb_state_e state_nxt;
  mesh_pkg::port_e      last_port;   // Most recent grant
  mesh_pkg::port_e      win_port;    // Next in rotation with a request
  logic                 win_val;
  logic                 free;        // Output register can be loaded

  // Empty, or the held word leaves on this edge
  assign free = (state == mesh_pkg::ARB_IDLE) || i_en;

  // Round-robin search
  // --------------------
  always_comb begin
    int idx;
    win_val  = 1'b0;
    win_port = last_port;
    // Start one past the last grant, wrap around once
    for (int i = 1; i <= mesh_pkg::NUM_PORTS; i++) begin
      idx = (int'(last_port) + i) % mesh_pkg::NUM_PORTS;
      if (!win_val && i_req[idx]) begin
        win_val  = 1'b1;
        win_port = mesh_pkg::port_e'(idx);
      end
    end
  end

  always_comb begin
    o_grant = '0;
    if (free && win_val) o_grant[win_port] = 1'b1;  // Pops the winning head
  end

  // FSM
  // --------------------
  always_comb begin
    state_nxt = state;
    case (state)
      mesh_pkg::ARB_IDLE: begin
        if (win_val) state_nxt = mesh_pkg::ARB_HOLD;   // Load now
      end
      mesh_pkg::ARB_HOLD: begin
        // Accepted with nothing behind it
        if (i_en && !win_val) state_nxt = mesh_pkg::ARB_IDLE;
      end
      default: state_nxt = mesh_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state     <= mesh_pkg::ARB_IDLE;
      last_port <= mesh_pkg::PORT_WEST;   // First search starts at local
    end else begin
      state <= state_nxt;
      if (|o_grant) last_port <= win_port;
    end
  end

  // Output register, payload only
  always_ff @(posedge clk) begin
    if (|o_grant) o_data <= i_heads[win_port];
  end

  assign o_data_val = (state == mesh_pkg::ARB_HOLD);

endmodule

/* logic/mesh_router.sv */
`timescale 1ns/1ps

module mesh_router #(
  parameter int X_LOC = 0,   // Column of this router
  parameter int Y_LOC = 0    // Row of this router
) (
  input  logic              clk,
  input  logic              i_rst,
  // Input links, one per port
  input  mesh_pkg::packet_t i_data     [mesh_pkg::NUM_PORTS],
  input  logic              i_data_val [mesh_pkg::NUM_PORTS],
  output logic              o_en       [mesh_pkg::NUM_PORTS],
  // Output links, one per port
  output mesh_pkg::packet_t o_data     [mesh_pkg::NUM_PORTS],
  output logic              o_data_val [mesh_pkg::NUM_PORTS],
  input  logic              i_en       [mesh_pkg::NUM_PORTS]
);

  // FIFO heads and pops, indexed by input port
  mesh_pkg::packet_t heads    [mesh_pkg::NUM_PORTS];
  logic              head_val [mesh_pkg::NUM_PORTS];
  logic              pop      [mesh_pkg::NUM_PORTS];
  mesh_pkg::port_e   route    [mesh_pkg::NUM_PORTS];   // Output wanted by each head

  // Arbiter side, outer index is the output port, bit index the input
  logic [mesh_pkg::NUM_PORTS-1:0] req   [mesh_pkg::NUM_PORTS];
  logic [mesh_pkg::NUM_PORTS-1:0] grant [mesh_pkg::NUM_PORTS];

  // Input FIFOs
  // --------------------
  for (genvar p = 0; p < mesh_pkg::NUM_PORTS; p++) begin : g_in
    mesh_input_fifo u_fifo (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_data     (i_data[p]),
      .i_data_val (i_data_val[p]),
      .o_en       (o_en[p]),        // Back to the upstream sender
      .i_pop      (pop[p]),
      .o_head     (heads[p]),
      .o_head_val (head_val[p])
    );
  end

  // XY route of each head
  // --------------------
  always_comb begin
    for (int p = 0; p < mesh_pkg::NUM_PORTS; p++) begin
      // X first
      if (heads[p].dst_x > mesh_pkg::coord_t'(X_LOC)) begin
        route[p] = mesh_pkg::PORT_EAST;
      end else if (heads[p].dst_x < mesh_pkg::coord_t'(X_LOC)) begin
        route[p] = mesh_pkg::PORT_WEST;
      // Column reached, then Y
      end else if (heads[p].dst_y > mesh_pkg::coord_t'(Y_LOC)) begin
        route[p] = mesh_pkg::PORT_NORTH;
      end else if (heads[p].dst_y < mesh_pkg::coord_t'(Y_LOC)) begin
        route[p] = mesh_pkg::PORT_SOUTH;
      end else begin
        route[p] = mesh_pkg::PORT_LOCAL;  // Arrived
      end
    end
  end

  // Request matrix, a valid head asks exactly one output
  always_comb begin
    for (int o = 0; o < mesh_pkg::NUM_PORTS; o++) begin
      for (int p = 0; p < mesh_pkg::NUM_PORTS; p++) begin
        req[o][p] = head_val[p] && (route[p] == mesh_pkg::port_e'(o));
      end
    end
  end

  // Pop is the OR of all grants aimed at that input
  always_comb begin
    for (int p = 0; p < mesh_pkg::NUM_PORTS; p++) begin
      pop[p] = 1'b0;
      for (int o = 0; o < mesh_pkg::NUM_PORTS; o++) begin
        pop[p] = pop[p] | grant[o][p];   // At most one set
      end
    end
  end

  // Output arbiters
  // --------------------
  for (genvar o = 0; o < mesh_pkg::NUM_PORTS; o++) begin : g_out
    mesh_output_arbiter u_arb (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_req      (req[o]),
      .i_heads    (heads),
      .o_grant    (grant[o]),
      .o_data     (o_data[o]),
      .o_data_val (o_data_val[o]),
      .i_en       (i_en[o])         // From the downstream receiver
    );
  end

endmodule

/* logic/mesh_network.sv */
`timescale 1ns/1ps

module mesh_network (
  input  logic              clk,
  input  logic              i_rst,
  // Nodes into the network, valid/enable
  input  mesh_pkg::packet_t i_data     [mesh_pkg::NUM_NODES],
  input  logic              i_data_val [mesh_pkg::NUM_NODES],
  output logic              o_en       [mesh_pkg::NUM_NODES],
  // Network out to the nodes, valid/enable
  output mesh_pkg::packet_t o_data     [mesh_pkg::NUM_NODES],
  output logic              o_data_val [mesh_pkg::NUM_NODES],
  input  logic              i_en       [mesh_pkg::NUM_NODES]
);

  // Router link wiring, indexed [y][x][port]
  // --------------------
  mesh_pkg::packet_t rtr_din
    [mesh_pkg::Y_NODES][mesh_pkg::X_NODES][mesh_pkg::NUM_PORTS];   // Into router inputs
  logic              rtr_din_val
    [mesh_pkg::Y_NODES][mesh_pkg::X_NODES][mesh_pkg::NUM_PORTS];
  logic              rtr_o_en
    [mesh_pkg::Y_NODES][mesh_pkg::X_NODES][mesh_pkg::NUM_PORTS];   // Input FIFO enables
  mesh_pkg::packet_t rtr_dout
    [mesh_pkg::Y_NODES][mesh_pkg::X_NODES][mesh_pkg::NUM_PORTS];   // From router outputs
  logic              rtr_dout_val
    [mesh_pkg::Y_NODES][mesh_pkg::X_NODES][mesh_pkg::NUM_PORTS];
  logic              rtr_i_en
    [mesh_pkg::Y_NODES][mesh_pkg::X_NODES][mesh_pkg::NUM_PORTS];   // Downstream enables

  for (genvar y = 0; y < mesh_pkg::Y_NODES; y++) begin : g_row
    for (genvar x = 0; x < mesh_pkg::X_NODES; x++) begin : g_col

      // Node on local port 0, node number y * X_NODES + x
      assign rtr_din[y][x][mesh_pkg::PORT_LOCAL]     = i_data[y*mesh_pkg::X_NODES+x];
      assign rtr_din_val[y][x][mesh_pkg::PORT_LOCAL] = i_data_val[y*mesh_pkg::X_NODES+x];
      assign rtr_i_en[y][x][mesh_pkg::PORT_LOCAL]    = i_en[y*mesh_pkg::X_NODES+x];
      assign o_en[y*mesh_pkg::X_NODES+x]       = rtr_o_en[y][x][mesh_pkg::PORT_LOCAL];
      assign o_data[y*mesh_pkg::X_NODES+x]     = rtr_dout[y][x][mesh_pkg::PORT_LOCAL];
      assign o_data_val[y*mesh_pkg::X_NODES+x] = rtr_dout_val[y][x][mesh_pkg::PORT_LOCAL];

      // North side, router above faces us with its south port
      if (y < mesh_pkg::Y_NODES - 1) begin : g_north
        assign rtr_din[y][x][mesh_pkg::PORT_NORTH]     = rtr_dout[y+1][x][mesh_pkg::PORT_SOUTH];
        assign rtr_din_val[y][x][mesh_pkg::PORT_NORTH] = rtr_dout_val[y+1][x][mesh_pkg::PORT_SOUTH];
        assign rtr_i_en[y][x][mesh_pkg::PORT_NORTH]    = rtr_o_en[y+1][x][mesh_pkg::PORT_SOUTH];
      end else begin : g_north_edge
        assign rtr_din[y][x][mesh_pkg::PORT_NORTH]     = '0;
        assign rtr_din_val[y][x][mesh_pkg::PORT_NORTH] = 1'b0;   // Never sends
        assign rtr_i_en[y][x][mesh_pkg::PORT_NORTH]    = 1'b0;   // Never accepts
      end

      // East side
      if (x < mesh_pkg::X_NODES - 1) begin : g_east
        assign rtr_din[y][x][mesh_pkg::PORT_EAST]     = rtr_dout[y][x+1][mesh_pkg::PORT_WEST];
        assign rtr_din_val[y][x][mesh_pkg::PORT_EAST] = rtr_dout_val[y][x+1][mesh_pkg::PORT_WEST];
        assign rtr_i_en[y][x][mesh_pkg::PORT_EAST]    = rtr_o_en[y][x+1][mesh_pkg::PORT_WEST];
      end else begin : g_east_edge
        assign rtr_din[y][x][mesh_pkg::PORT_EAST]     = '0;
        assign rtr_din_val[y][x][mesh_pkg::PORT_EAST] = 1'b0;
        assign rtr_i_en[y][x][mesh_pkg::PORT_EAST]    = 1'b0;
      end

      // South side
      if (y > 0) begin : g_south
        assign rtr_din[y][x][mesh_pkg::PORT_SOUTH]     = rtr_dout[y-1][x][mesh_pkg::PORT_NORTH];
        assign rtr_din_val[y][x][mesh_pkg::PORT_SOUTH] = rtr_dout_val[y-1][x][mesh_pkg::PORT_NORTH];
        assign rtr_i_en[y][x][mesh_pkg::PORT_SOUTH]    = rtr_o_en[y-1][x][mesh_pkg::PORT_NORTH];
      end else begin : g_south_edge
        assign rtr_din[y][x][mesh_pkg::PORT_SOUTH]     = '0;
        assign rtr_din_val[y][x][mesh_pkg::PORT_SOUTH] = 1'b0;
        assign rtr_i_en[y][x][mesh_pkg::PORT_SOUTH]    = 1'b0;
      end

      // West side
      if (x > 0) begin : g_west
        assign rtr_din[y][x][mesh_pkg::PORT_WEST]     = rtr_dout[y][x-1][mesh_pkg::PORT_EAST];
        assign rtr_din_val[y][x][mesh_pkg::PORT_WEST] = rtr_dout_val[y][x-1][mesh_pkg::PORT_EAST];
        assign rtr_i_en[y][x][mesh_pkg::PORT_WEST]    = rtr_o_en[y][x-1][mesh_pkg::PORT_EAST];
      end else begin : g_west_edge
        assign rtr_din[y][x][mesh_pkg::PORT_WEST]     = '0;
        assign rtr_din_val[y][x][mesh_pkg::PORT_WEST] = 1'b0;
        assign rtr_i_en[y][x][mesh_pkg::PORT_WEST]    = 1'b0;
      end

      // Router at column x, row y
      // --------------------
      mesh_router #(
        .X_LOC (x),
        .Y_LOC (y)
      ) u_router (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_data     (rtr_din[y][x]),       // From neighbours and node
        .i_data_val (rtr_din_val[y][x]),
        .o_en       (rtr_o_en[y][x]),      // Back upstream
        .o_data     (rtr_dout[y][x]),      // Toward neighbours and node
        .o_data_val (rtr_dout_val[y][x]),
        .i_en       (rtr_i_en[y][x])
      );
    end
  end

endmodule

/* verif/mesh_tb.sv */
`timescale 1ns/1ps

module mesh_tb;

  localparam int PKTS_PER_NODE = 40;
  localparam int NUM_PAIRS     = mesh_pkg::NUM_NODES * mesh_pkg::NUM_NODES;
  localparam int TIMEOUT       = 200 * mesh_pkg::NUM_NODES * PKTS_PER_NODE + 1000;
  localparam int STALL_START   = 80;    // All nodes refuse output in this window
  localparam int STALL_END     = 200;
  localparam int DRAIN_CYCLES  = 50;    // Quiet time before the final check

  // DUT ports
  logic              clk;
  logic              i_rst;
  mesh_pkg::packet_t i_data     [mesh_pkg::NUM_NODES];
  logic              i_data_val [mesh_pkg::NUM_NODES];
  logic              o_en       [mesh_pkg::NUM_NODES];
  mesh_pkg::packet_t o_data     [mesh_pkg::NUM_NODES];
  logic              o_data_val [mesh_pkg::NUM_NODES];
  logic              i_en       [mesh_pkg::NUM_NODES];

  // Model and stimulus state
  // --------------------
  integer            seed;
  mesh_pkg::packet_t model_q  [NUM_PAIRS][$];          // Index src * 16 + dst
  mesh_pkg::packet_t cur_pkt  [mesh_pkg::NUM_NODES];   // Offered word per node
  logic              busy     [mesh_pkg::NUM_NODES];   // Offer not yet accepted
  int                made     [mesh_pkg::NUM_NODES];   // Packets created, also next seq
  logic              held     [mesh_pkg::NUM_NODES];   // Output stalled last edge
  mesh_pkg::packet_t held_pkt [mesh_pkg::NUM_NODES];
  int                cycle_count;
  int                outstanding;                      // Accepted, not yet delivered
  int                delivered;
  logic              draining;

  mesh_network DUT (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .i_en       (i_en)
  );

  always #2 clk = ~clk;   // 4 ns period

  // Helpers
  // --------------------
  task automatic fail_now(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_packet(input string name, input mesh_pkg::packet_t got,
                              input mesh_pkg::packet_t exp);
    if (got !== exp) fail_now($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  function automatic logic chance(input int pct);
    int r;
    r = $random(seed);
    return ((r & 32'h7fff_ffff) % 100) < pct;
  endfunction

  function automatic int dst_node(input mesh_pkg::packet_t p);
    return int'(p.dst_y) * mesh_pkg::X_NODES + int'(p.dst_x);
  endfunction

  // First packet to self, second corner to corner, rest random
  function automatic int pick_dst(input int src, input int seq);
    int r;
    r = $random(seed);
    if (seq == 0) return src;
    if (seq == 1 && src == 0) return mesh_pkg::NUM_NODES - 1;
    if (seq == 1 && src == mesh_pkg::NUM_NODES - 1) return 0;
    return (r & 32'h7fff_ffff) % mesh_pkg::NUM_NODES;
  endfunction

  function automatic mesh_pkg::packet_t make_packet(input int src, input int dst, input int seq);
    mesh_pkg::packet_t p;
    p.dst_x   = mesh_pkg::coord_t'(dst % mesh_pkg::X_NODES);
    p.dst_y   = mesh_pkg::coord_t'(dst / mesh_pkg::X_NODES);
    p.src     = mesh_pkg::node_id_t'(src);
    p.payload = {mesh_pkg::node_id_t'(src), 12'(seq)};   // Source and sequence number
    return p;
  endfunction

  function automatic logic all_sent();
    for (int n = 0; n < mesh_pkg::NUM_NODES; n++) begin
      if (made[n] < PKTS_PER_NODE || busy[n]) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Edge sampling, before any input changes
  // --------------------
  task automatic sample_edge();
    mesh_pkg::packet_t got;
    mesh_pkg::packet_t exp;
    int                pair;
    cycle_count++;
    if (cycle_count > TIMEOUT) begin
      fail_now($sformatf("timeout after %0d cycles, %0d packets were not delivered in time",
                         cycle_count, outstanding));
    end
    for (int n = 0; n < mesh_pkg::NUM_NODES; n++) begin
      if (held[n]) begin                           // Stalled word must stay put
        check_bit($sformatf("o_data_val[%0d]", n), o_data_val[n], 1'b1);
        check_packet($sformatf("o_data[%0d]", n), o_data[n], held_pkt[n]);
      end
      held[n]     = o_data_val[n] && !i_en[n];
      held_pkt[n] = o_data[n];
      if (i_data_val[n] && o_en[n]) begin          // Injection taken by the network
        pair = n * mesh_pkg::NUM_NODES + dst_node(i_data[n]);
        model_q[pair].push_back(i_data[n]);
        outstanding++;
        busy[n] = 1'b0;
      end
      if (o_data_val[n] && i_en[n]) begin          // Arrival at node n
        got  = o_data[n];
        pair = int'(got.src) * mesh_pkg::NUM_NODES + n;
        if (model_q[pair].size() == 0) begin
          fail_now($sformatf("node %0d received a packet from node %0d that was never sent to it",
                             n, got.src));
        end else begin
          exp = model_q[pair].pop_front();         // Oldest for this pair
          check_packet($sformatf("o_data[%0d]", n), got, exp);
          outstanding--;
          delivered++;
        end
      end
    end
  endtask

  // New offers and output enables, 0.5 ns after the edge
  task automatic drive_inputs();
    int dst;
    for (int n = 0; n < mesh_pkg::NUM_NODES; n++) begin
      if (!busy[n] && !draining && made[n] < PKTS_PER_NODE && chance(35)) begin
        dst        = pick_dst(n, made[n]);
        cur_pkt[n] = make_packet(n, dst, made[n]);
        made[n]++;
        busy[n] = 1'b1;
      end
      i_data[n]     = cur_pkt[n];                  // Held until accepted
      i_data_val[n] = busy[n];
      if (draining) i_en[n] = 1'b1;
      else if (cycle_count >= STALL_START && cycle_count < STALL_END) i_en[n] = 1'b0;
      else i_en[n] = !chance(40);                  // About 40 percent refused
    end
  endtask

  task automatic run_cycle();
    @(posedge clk);
    sample_edge();
    #0.5;
    drive_inputs();
  endtask

  // Main sequence
  // --------------------
  initial begin
    seed        = 51450;
    clk         = 1'b0;
    i_rst       = 1'b1;
    cycle_count = 0;
    outstanding = 0;
    delivered   = 0;
    draining    = 1'b0;
    for (int n = 0; n < mesh_pkg::NUM_NODES; n++) begin
      i_data[n]     = '0;
      i_data_val[n] = 1'b0;
      i_en[n]       = 1'b1;
      cur_pkt[n]    = '0;
      busy[n]       = 1'b0;
      made[n]       = 0;
      held[n]       = 1'b0;
      held_pkt[n]   = '0;
    end
    repeat (10) @(posedge clk);
    #0.5 i_rst = 1'b0;
    @(posedge clk);
    for (int n = 0; n < mesh_pkg::NUM_NODES; n++) begin   // Idle state out of reset
      check_bit($sformatf("o_data_val[%0d]", n), o_data_val[n], 1'b0);
      check_bit($sformatf("o_en[%0d]", n), o_en[n], 1'b1);
    end
    #0.5;
    drive_inputs();
    while (!all_sent() || outstanding != 0) run_cycle();
    draining = 1'b1;                                    // Enables high, no new offers
    repeat (DRAIN_CYCLES) run_cycle();
    // Drained network, no word left in an output register or a node FIFO
    for (int n = 0; n < mesh_pkg::NUM_NODES; n++) begin
      check_bit($sformatf("o_data_val[%0d]", n), o_data_val[n], 1'b0);
      check_bit($sformatf("o_en[%0d]", n), o_en[n], 1'b1);
    end
    $display("%0d packets delivered in %0d cycles", delivered, cycle_count);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* project.f */
logic/mesh_pkg.sv
logic/mesh_input_fifo.sv
logic/mesh_output_arbiter.sv
logic/mesh_router.sv
logic/mesh_network.sv
verif/mesh_tb.sv

/* Makefile */
# Verilator build and run of the mesh network testbench

TOP := mesh_tb
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): project.f $(wildcard logic/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f

# Pass only if the pass line shows up in the output
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
